// File: all.f
+incdir+rtl
rtl/vrf_pkg.sv
rtl/vrf_iter_counter.sv
rtl/vrf_seq_fsm.sv
rtl/vrf_operand_regs.sv
rtl/vrf_port.sv
bench/vrf_port_chk.sv
bench/tb_vrf_port.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vrf_port
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_vrf_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "vrf_macros.svh"

module tb_vrf_port;

  import vrf_pkg::*;

  localparam int unsigned NUM_OPS = 48;
  localparam int unsigned TIMEOUT = 200 * NUM_OPS;

  logic      clk_i, rst_ni, req_i;
  vrf_sel_t  sel_i;
  vrf_vl_t   vl_i;
  vrf_sew_e  sew_i;
  vrf_word_t wdata_i, data_rdata_i, data_wdata_o, rdata_a_o, rdata_b_o;
  vrf_be_t   data_be_o;
  logic      data_req_o, data_gnt_i, data_rvalid_i, data_we_o, vector_done_o;
  logic      agu_load_o, agu_get_rs1_o, agu_get_rs2_o, agu_get_rd_o, agu_incr_o;

  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned incr_cnt = 0;
  int unsigned done_cnt = 0;
  int unsigned load_cnt = 0;
  int unsigned exp_total = 0;

  // One-hot access kinds of the running operation as in sel
  vrf_sel_t exp_kind[$];
  vrf_be_t  exp_be[$];
  vrf_sel_t act_kind[$];
  vrf_be_t  act_be[$];
  // Reads granted but not yet answered
  vrf_sel_t rd_q[$];

  logic      opnd_chk = 1'b0;
  vrf_sel_t  opnd_kind;
  vrf_word_t opnd_val;

  vrf_port dut_i (.*);

  ////////////////////////////////////////
  // Compare tasks and reference
  ////////////////////////////////////////

  task automatic note_result(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input vrf_word_t got, input vrf_word_t exp);
    note_result(name, got, exp);
  endtask

  task automatic check_be(input string name, input vrf_be_t got, input vrf_be_t exp);
    note_result(name, 32'(got), 32'(exp));
  endtask

  task automatic check_sel(input string name, input vrf_sel_t got, input vrf_sel_t exp);
    note_result(name, 32'(got), 32'(exp));
  endtask

  task automatic check_count(input string name, input int unsigned got, input int unsigned exp);
    note_result(name, got, exp);
  endtask

  // Words to step through and byte enables of the last word
  function automatic int unsigned ref_words(input vrf_vl_t vl, input vrf_sew_e sew,
                                            output vrf_be_t tail);
    int unsigned bytes;
    bytes = vl * ((sew == SEW8) ? 1 : (sew == SEW16) ? 2 : 4);
    tail  = '1;
    if ((bytes % `VRF_BE_W) != 0) tail = vrf_be_t'((1 << (bytes % `VRF_BE_W)) - 1);
    return (bytes + `VRF_BE_W - 1) / `VRF_BE_W;
  endfunction

  task automatic run_op(input vrf_sel_t sel, input vrf_vl_t vl, input vrf_sew_e sew);
    vrf_be_t     tail;
    int unsigned words;
    int unsigned done_base;
    int unsigned load_base;
    int unsigned n;
    words = ref_words(vl, sew, tail);
    exp_kind.delete();
    exp_be.delete();
    act_kind.delete();
    act_be.delete();
    // Order within an iteration is A, B, then RD
    for (int w = 0; w < int'(words); w++) begin
      for (int k = 0; k < 3; k++) begin
        if (sel[k]) begin
          exp_kind.push_back(vrf_sel_t'(1 << k));
          exp_be.push_back((w == int'(words) - 1) ? tail : vrf_be_t'('1));
        end
      end
    end
    exp_total += exp_kind.size();
    done_base = done_cnt;
    load_base = load_cnt;
    @(negedge clk_i);
    sel_i <= sel;
    vl_i  <= vl;
    sew_i <= sew;
    req_i <= 1'b1;
    @(negedge clk_i);
    req_i <= 1'b0;
    if (sel != '0) begin
      while (done_cnt == done_base) @(negedge clk_i);
    end else begin
      repeat (4) @(negedge clk_i);
    end
    // Last read data may still be on its way
    while (rd_q.size() != 0 || opnd_chk) @(negedge clk_i);
    check_count("agu_load_o pulses", load_cnt - load_base, 1);
    check_count("vector_done_o pulses", done_cnt - done_base, (sel != '0) ? 1 : 0);
    check_count("access count", act_kind.size(), exp_kind.size());
    n = (act_kind.size() < exp_kind.size()) ? act_kind.size() : exp_kind.size();
    for (int i = 0; i < int'(n); i++) begin
      check_sel($sformatf("agu_get strobes of access %0d", i), act_kind[i], exp_kind[i]);
      check_be($sformatf("data_be_o of access %0d", i), act_be[i], exp_be[i]);
    end
  endtask

  ////////////////////////////////////////
  // Clock, memory model and monitor
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Random grant stalls; read data due no later than the next grant
  initial begin
    logic grant;
    logic rd_pending;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    wdata_i       = '0;
    rd_pending    = 1'b0;
    forever begin
      @(negedge clk_i);
      grant = data_req_o && ($urandom_range(3, 0) != 0);
      data_rvalid_i <= 1'b0;
      if (rd_pending && (grant || $urandom_range(1, 0) == 1)) begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= $urandom();
        rd_pending = 1'b0;
      end
      if (grant && !data_we_o) rd_pending = 1'b1;
      data_gnt_i <= grant;
      wdata_i    <= $urandom();
    end
  end

  initial begin
    vrf_sel_t kind;
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        // Operand register loaded on the previous edge
        if (opnd_chk) begin
          if (opnd_kind[0]) check_word("rdata_a_o", rdata_a_o, opnd_val);
          else check_word("rdata_b_o", rdata_b_o, opnd_val);
          opnd_chk = 1'b0;
        end
        if (data_rvalid_i && rd_q.size() != 0) begin
          opnd_kind = rd_q.pop_front();
          opnd_val  = data_rdata_i;
          opnd_chk  = 1'b1;
        end
        if (data_req_o && data_gnt_i) begin
          kind = {agu_get_rd_o & data_we_o, agu_get_rs2_o & ~data_we_o,
                  agu_get_rs1_o & ~data_we_o};
          act_kind.push_back(kind);
          act_be.push_back(data_be_o);
          if (data_we_o) check_word("data_wdata_o", data_wdata_o, wdata_i);
          else rd_q.push_back(kind);
        end
        if (agu_incr_o) incr_cnt++;
        if (agu_load_o) load_cnt++;
        if (vector_done_o) done_cnt++;
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    vrf_sel_t sel;
    vrf_sew_e sew;
    vrf_vl_t  vl;
    void'($urandom(32'h1115));
    rst_ni = 1'b0;
    req_i  = 1'b0;
    sel_i  = '0;
    vl_i   = '0;
    sew_i  = SEW8;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni <= 1'b1;
    if (data_req_o || data_we_o || agu_load_o || agu_incr_o || vector_done_o ||
        agu_get_rs1_o || agu_get_rs2_o || agu_get_rd_o) begin
      errors++;
      $display("Memory request or AGU strobe active right after reset");
    end
    check_word("rdata_a_o", rdata_a_o, '0);
    check_word("rdata_b_o", rdata_b_o, '0);

    for (int op = 0; op < int'(NUM_OPS); op++) begin
      sel = vrf_sel_t'(op % 8);
      case ($urandom_range(2, 0))
        0: sew = SEW8;
        1: sew = SEW16;
        default: sew = SEW32;
      endcase
      // Stay within one vector register
      vl = $urandom_range((`VRF_VLEN / 8) >> sew, 1);
      run_op(sel, vl, sew);
    end

    check_count("agu_incr_o pulses", incr_cnt, exp_total);
    errors += dut_i.u_chk.fail_cnt;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    int unsigned cycles;
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/vrf_port_chk.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_port_chk (
  input wire logic        clk_i,
  input wire logic        rst_ni,
  input wire logic        data_req_i,
  input wire logic        data_gnt_i,
  input wire logic        data_we_i,
  input vrf_pkg::vrf_be_t data_be_i,
  input wire logic        agu_get_rs1_i,
  input wire logic        agu_get_rs2_i,
  input wire logic        agu_get_rd_i,
  input wire logic        agu_incr_i,
  input wire logic        vector_done_i
);

  int unsigned fail_cnt = 0;

  // Stalled access keeps its request and strobes
  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_i && !data_gnt_i |=> data_req_i &&
      $stable({data_we_i, data_be_i, agu_get_rs1_i, agu_get_rs2_i, agu_get_rd_i}))
    else begin
      fail_cnt++;
      $error("Access strobes changed while the request waited for a grant");
    end

  done_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(vector_done_i && data_req_i))
    else begin
      fail_cnt++;
      $error("vector_done_o high together with data_req_o");
    end

  incr_on_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    agu_incr_i |-> data_req_i && data_gnt_i)
    else begin
      fail_cnt++;
      $error("agu_incr_o pulsed without a granted access");
    end

endmodule

bind vrf_port vrf_port_chk u_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .data_req_i    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_we_i     (data_we_o),
  .data_be_i     (data_be_o),
  .agu_get_rs1_i (agu_get_rs1_o),
  .agu_get_rs2_i (agu_get_rs2_o),
  .agu_get_rd_i  (agu_get_rd_o),
  .agu_incr_i    (agu_incr_o),
  .vector_done_i (vector_done_o)
);

`default_nettype wire

// File: rtl/vrf_port.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_port (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,

  // Pipeline side
  input  wire logic          req_i,
  input  vrf_pkg::vrf_sel_t  sel_i,
  input  vrf_pkg::vrf_vl_t   vl_i,
  input  vrf_pkg::vrf_sew_e  sew_i,
  input  vrf_pkg::vrf_word_t wdata_i,
  output vrf_pkg::vrf_word_t rdata_a_o,
  output vrf_pkg::vrf_word_t rdata_b_o,
  output logic               vector_done_o,

  // Data memory port
  output logic               data_req_o,
  input  wire logic          data_gnt_i,
  input  wire logic          data_rvalid_i,
  output logic               data_we_o,
  output vrf_pkg::vrf_be_t   data_be_o,
  output vrf_pkg::vrf_word_t data_wdata_o,
  input  vrf_pkg::vrf_word_t data_rdata_i,

  // AGU strobes
  output logic               agu_load_o,
  output logic               agu_get_rs1_o,
  output logic               agu_get_rs2_o,
  output logic               agu_get_rd_o,
  output logic               agu_incr_o
);

  logic load;
  logic step;
  logic last;
  logic rd_a_grant;
  logic rd_b_grant;

  vrf_seq_fsm u_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .sel_i         (sel_i),
    .data_gnt_i    (data_gnt_i),
    .last_i        (last),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .agu_load_o    (agu_load_o),
    .agu_get_rs1_o (agu_get_rs1_o),
    .agu_get_rs2_o (agu_get_rs2_o),
    .agu_get_rd_o  (agu_get_rd_o),
    .agu_incr_o    (agu_incr_o),
    .load_o        (load),
    .step_o        (step),
    .rd_a_grant_o  (rd_a_grant),
    .rd_b_grant_o  (rd_b_grant),
    .vector_done_o (vector_done_o)
  );

  vrf_iter_counter u_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (load),
    .step_i (step),
    .vl_i   (vl_i),
    .sew_i  (sew_i),
    .last_o (last),
    .be_o   (data_be_o)
  );

  vrf_operand_regs u_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_a_grant_i  (rd_a_grant),
    .rd_b_grant_i  (rd_b_grant),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rdata_a_o     (rdata_a_o),
    .rdata_b_o     (rdata_b_o)
  );

  // Result goes straight to memory
  assign data_wdata_o = wdata_i;

endmodule

`default_nettype wire

// File: rtl/vrf_operand_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_operand_regs (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          rd_a_grant_i,
  input  wire logic          rd_b_grant_i,
  input  wire logic          data_rvalid_i,
  input  vrf_pkg::vrf_word_t data_rdata_i,
  output vrf_pkg::vrf_word_t rdata_a_o,
  output vrf_pkg::vrf_word_t rdata_b_o
);

  import vrf_pkg::*;

  logic      pend_a_q;
  logic      pend_b_q;
  vrf_word_t op_a_q;
  vrf_word_t op_b_q;

  // Target of the outstanding read
  // A new grant may coincide with rvalid of the previous read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_a_q <= 1'b0;
      pend_b_q <= 1'b0;
    end else if (rd_a_grant_i || rd_b_grant_i) begin
      pend_a_q <= rd_a_grant_i;
      pend_b_q <= rd_b_grant_i;
    end else if (data_rvalid_i) begin
      pend_a_q <= 1'b0;
      pend_b_q <= 1'b0;
    end
  end

  // Operand capture
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_a_q <= '0;
      op_b_q <= '0;
    end else if (data_rvalid_i) begin
      if (pend_a_q) op_a_q <= data_rdata_i;
      if (pend_b_q) op_b_q <= data_rdata_i;
    end
  end

  assign rdata_a_o = op_a_q;
  assign rdata_b_o = op_b_q;

endmodule

`default_nettype wire

// File: rtl/vrf_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_seq_fsm (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          req_i,
  input  vrf_pkg::vrf_sel_t  sel_i,
  input  wire logic          data_gnt_i,
  input  wire logic          last_i,
  output logic               data_req_o,
  output logic               data_we_o,
  output logic               agu_load_o,
  output logic               agu_get_rs1_o,
  output logic               agu_get_rs2_o,
  output logic               agu_get_rd_o,
  output logic               agu_incr_o,
  output logic               load_o,
  output logic               step_o,
  output logic               rd_a_grant_o,
  output logic               rd_b_grant_o,
  output logic               vector_done_o
);

  import vrf_pkg::*;

  vrf_state_e state_q, state_d;
  vrf_state_e acc;
  logic       done_q;

  // First selected access of an iteration, IDLE when none is selected
  function automatic vrf_state_e first_acc(input vrf_sel_t sel);
    if (sel[0]) begin
      return VRF_READ1;
    end else if (sel[1]) begin
      return VRF_READ2;
    end else if (sel[2]) begin
      return VRF_WRITE;
    end
    return VRF_IDLE;
  endfunction

  // Access following cur in the same iteration, IDLE at its end
  function automatic vrf_state_e next_acc(input vrf_state_e cur, input vrf_sel_t sel);
    vrf_state_e nxt;
    nxt = VRF_IDLE;
    case (cur)
      VRF_READ1: begin
        if (sel[1]) begin
          nxt = VRF_READ2;
        end else if (sel[2]) begin
          nxt = VRF_WRITE;
        end
      end
      VRF_READ2: begin
        if (sel[2]) nxt = VRF_WRITE;
      end
      default: nxt = VRF_IDLE;
    endcase
    return nxt;
  endfunction

  ////////////////////////////////////////
  // Next state and access issue
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    acc           = VRF_IDLE;
    data_req_o    = 1'b0;
    data_we_o     = 1'b0;
    agu_load_o    = 1'b0;
    agu_get_rs1_o = 1'b0;
    agu_get_rs2_o = 1'b0;
    agu_get_rd_o  = 1'b0;
    agu_incr_o    = 1'b0;
    load_o        = 1'b0;
    step_o        = 1'b0;
    rd_a_grant_o  = 1'b0;
    rd_b_grant_o  = 1'b0;
    vector_done_o = 1'b0;

    case (state_q)
      VRF_IDLE: begin
        if (req_i) begin
          agu_load_o = 1'b1;
          load_o     = 1'b1;
          state_d    = VRF_START;
        end
      end

      // Nothing selected, back to idle without a done pulse
      VRF_START: begin
        acc = first_acc(sel_i);
        if (acc == VRF_IDLE) state_d = VRF_IDLE;
      end

      VRF_READ1, VRF_READ2, VRF_WRITE: begin
        acc = next_acc(state_q, sel_i);
        if (acc == VRF_IDLE) begin
          // Iteration finished on the previous grant
          if (done_q) begin
            vector_done_o = 1'b1;
            state_d       = VRF_IDLE;
          end else begin
            acc = first_acc(sel_i);
            if (acc == VRF_IDLE) state_d = VRF_IDLE;
          end
        end
      end

      default: state_d = VRF_IDLE;
    endcase

    // Request and strobes hold until granted
    if (acc != VRF_IDLE) begin
      data_req_o    = 1'b1;
      data_we_o     = (acc == VRF_WRITE);
      agu_get_rs1_o = (acc == VRF_READ1);
      agu_get_rs2_o = (acc == VRF_READ2);
      agu_get_rd_o  = (acc == VRF_WRITE);
      if (data_gnt_i) begin
        agu_incr_o   = 1'b1;
        rd_a_grant_o = (acc == VRF_READ1);
        rd_b_grant_o = (acc == VRF_READ2);
        step_o       = (next_acc(acc, sel_i) == VRF_IDLE);
        state_d      = acc;
      end
    end
  end

  ////////////////////////////////////////
  // State registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= VRF_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Counter still holds the pre-step count here
      if (load_o) begin
        done_q <= 1'b0;
      end else if (step_o) begin
        done_q <= last_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/vrf_iter_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "vrf_macros.svh"

module vrf_iter_counter (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               load_i,
  input  wire logic               step_i,
  input  vrf_pkg::vrf_vl_t        vl_i,
  input  vrf_pkg::vrf_sew_e       sew_i,
  output logic                    last_o,
  output vrf_pkg::vrf_be_t        be_o
);

  import vrf_pkg::*;

  localparam int unsigned OFF_W = $clog2(`VRF_BE_W);

  vrf_vl_t            byte_cnt;
  vrf_iter_t          word_cnt;
  vrf_iter_t          count_q;
  logic [OFF_W-1:0]   offset_q;
  vrf_be_t            tail_be;

  ////////////////////////////////////////
  // Word count and tail offset
  ////////////////////////////////////////

  // Element width code is log2 of the element size in bytes
  assign byte_cnt = vl_i << sew_i;

  // Partial last word counts as a full iteration
  assign word_cnt = vrf_iter_t'(byte_cnt >> OFF_W)
                  + vrf_iter_t'(|byte_cnt[OFF_W-1:0]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q  <= '0;
      offset_q <= '0;
    end else if (load_i) begin
      count_q  <= word_cnt;
      offset_q <= byte_cnt[OFF_W-1:0];
    end else if (step_i && (count_q != '0)) begin
      count_q <= count_q - vrf_iter_t'(1);
    end
  end

  // Zero length runs a single iteration instead of hanging
  assign last_o = (count_q <= vrf_iter_t'(1));

  ////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////

  // Low offset bytes live in the tail word
  always_comb begin
    for (int i = 0; i < `VRF_BE_W; i++) begin
      tail_be[i] = (i < int'(offset_q));
    end
  end

  always_comb begin
    if (last_o && (offset_q != '0)) begin
      be_o = tail_be;
    end else begin
      be_o = '1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/vrf_pkg.sv
`default_nettype none

`include "vrf_macros.svh"

package vrf_pkg;

  // One word on the data memory port
  typedef logic [`VRF_WORD_W-1:0] vrf_word_t;

  // Byte enables of one word
  typedef logic [`VRF_BE_W-1:0] vrf_be_t;

  // Vector length from the CSR
  typedef logic [31:0] vrf_vl_t;

  // Remaining word count
  typedef logic [29:0] vrf_iter_t;

  // Operation select, bit 0 reads A, bit 1 reads B, bit 2 writes RD
  typedef logic [2:0] vrf_sel_t;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } vrf_sew_e;

  // READ1, READ2 and WRITE name the access granted last
  typedef enum logic [2:0] {
    VRF_IDLE  = 3'd0,
    VRF_START = 3'd1,
    VRF_READ1 = 3'd2,
    VRF_READ2 = 3'd3,
    VRF_WRITE = 3'd4
  } vrf_state_e;

endpackage

`default_nettype wire

// File: rtl/vrf_macros.svh
`ifndef VRF_MACROS_SVH
`define VRF_MACROS_SVH

// Data memory word width
`define VRF_WORD_W 32

// Byte lanes per memory word
`define VRF_BE_W 4

// Vector register length in bits
`define VRF_VLEN 128

`endif
